//--- Bender.yml
package:
  name: ooo_alu_cluster

sources:
  - logic/rs_pkg.sv
  - logic/rs_ctrl.sv
  - logic/rs_entry_file.sv
  - logic/alu_pipe.sv
  - logic/ooo_alu_cluster.sv
  - target: test
    files:
      - verif/ooo_alu_cluster_props.sv
      - verif/ooo_alu_cluster_tb.sv

//--- logic/alu_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module alu_pipe import rs_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,
    input  wire logic     valid_i,
    input  wire alu_op_e  op_i,
    input  wire word_t    a_i,
    input  wire word_t    b_i,
    input  wire rob_tag_t dst_tag_i,
    output logic          cdb_valid_o,
    output rob_tag_t      cdb_tag_o,
    output word_t         cdb_value_o
);

    // Stage one operand registers
    logic                    s1_valid_q;
    alu_op_e                 s1_op_q;
    word_t                   s1_a_q;
    word_t                   s1_b_q;
    rob_tag_t                s1_tag_q;

    word_t                   result;
    logic [$clog2(XLEN)-1:0] shamt;

    // Stage one
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            s1_op_q  <= op_i;
            s1_a_q   <= a_i;
            s1_b_q   <= b_i;
            s1_tag_q <= dst_tag_i;
        end
    end

    // Low bits of b only
    assign shamt = s1_b_q[$clog2(XLEN)-1:0];

    // Stage two compute
    always_comb begin
        case (s1_op_q)
            ALU_ADD:  result = s1_a_q + s1_b_q;
            ALU_SUB:  result = s1_a_q - s1_b_q;
            ALU_AND:  result = s1_a_q & s1_b_q;
            ALU_OR:   result = s1_a_q | s1_b_q;
            ALU_XOR:  result = s1_a_q ^ s1_b_q;
            ALU_SLL:  result = s1_a_q << shamt;
            ALU_SRL:  result = s1_a_q >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  result = word_t'($signed(s1_a_q) >>> shamt);
            ALU_SLT:  result = word_t'($signed(s1_a_q) < $signed(s1_b_q));
            ALU_SLTU: result = word_t'(s1_a_q < s1_b_q);
            default:  result = '0;
        endcase
    end

    // Stage two onto the CDB
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= s1_valid_q && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            cdb_tag_o   <= s1_tag_q;
            cdb_value_o <= result;
        end
    end

endmodule

`default_nettype wire

//--- logic/ooo_alu_cluster.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_alu_cluster import rs_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,
    // Renamed instruction from issue
    input  wire logic     issue_valid_i,
    input  wire alu_op_e  issue_op_i,
    input  wire rob_tag_t issue_dst_tag_i,
    input  wire logic     issue_a_ready_i,
    input  wire word_t    issue_a_value_i,
    input  wire rob_tag_t issue_a_tag_i,
    input  wire logic     issue_b_ready_i,
    input  wire word_t    issue_b_value_i,
    input  wire rob_tag_t issue_b_tag_i,
    // Broadcasts from other units
    input  wire logic     ext_cdb_valid_i,
    input  wire rob_tag_t ext_cdb_tag_i,
    input  wire word_t    ext_cdb_value_i,
    output logic          credit_return_o,
    output logic          cdb_valid_o,
    output rob_tag_t      cdb_tag_o,
    output word_t         cdb_value_o
);

    logic [RS_DEPTH-1:0] alloc_we;
    logic [RS_DEPTH-1:0] operands_ready;
    rs_idx_t             sel_idx;
    logic                dispatch_valid;

    // Operands of the dispatching entry
    alu_op_e             sel_op;
    word_t               sel_a;
    word_t               sel_b;
    rob_tag_t            sel_dst_tag;

    rs_ctrl u_rs_ctrl (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .issue_valid_i    (issue_valid_i),
        .operands_ready_i (operands_ready),
        .alloc_we_o       (alloc_we),
        .sel_idx_o        (sel_idx),
        .dispatch_valid_o (dispatch_valid),
        .credit_return_o  (credit_return_o)
    );

    // Own CDB loops back for wakeup next to the external one
    rs_entry_file u_rs_entry_file (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .alloc_we_i       (alloc_we),
        .issue_op_i       (issue_op_i),
        .issue_dst_tag_i  (issue_dst_tag_i),
        .issue_a_ready_i  (issue_a_ready_i),
        .issue_a_value_i  (issue_a_value_i),
        .issue_a_tag_i    (issue_a_tag_i),
        .issue_b_ready_i  (issue_b_ready_i),
        .issue_b_value_i  (issue_b_value_i),
        .issue_b_tag_i    (issue_b_tag_i),
        .int_cdb_valid_i  (cdb_valid_o),
        .int_cdb_tag_i    (cdb_tag_o),
        .int_cdb_value_i  (cdb_value_o),
        .ext_cdb_valid_i  (ext_cdb_valid_i),
        .ext_cdb_tag_i    (ext_cdb_tag_i),
        .ext_cdb_value_i  (ext_cdb_value_i),
        .sel_idx_i        (sel_idx),
        .operands_ready_o (operands_ready),
        .sel_op_o         (sel_op),
        .sel_a_o          (sel_a),
        .sel_b_o          (sel_b),
        .sel_dst_tag_o    (sel_dst_tag)
    );

    alu_pipe u_alu_pipe (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .valid_i     (dispatch_valid),
        .op_i        (sel_op),
        .a_i         (sel_a),
        .b_i         (sel_b),
        .dst_tag_i   (sel_dst_tag),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_value_o (cdb_value_o)
    );

endmodule

`default_nettype wire

//--- logic/rs_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module rs_ctrl import rs_pkg::*; (
    input  wire logic                clk,
    input  wire logic                arst_n_i,
    input  wire logic                flush_i,
    input  wire logic                issue_valid_i,
    input  wire logic [RS_DEPTH-1:0] operands_ready_i,
    output logic [RS_DEPTH-1:0]      alloc_we_o,
    output rs_idx_t                  sel_idx_o,
    output logic                     dispatch_valid_o,
    output logic                     credit_return_o
);

    // Per-entry lifecycle
    entry_state_e        state_q [RS_DEPTH];

    logic [RS_DEPTH-1:0] free_vec;
    logic [RS_DEPTH-1:0] eligible_vec;
    logic [RS_DEPTH-1:0] issued_vec;

    // Dispatch choice for this cycle
    logic                pick_valid;
    rs_idx_t             pick_idx;

    logic                dispatch_q;

    // Decode entry states into flat vectors
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_vec[i]     = (state_q[i] == ENT_FREE);
            // Only waiting entries with both operands in hand may go
            eligible_vec[i] = (state_q[i] == ENT_WAIT) && operands_ready_i[i];
            issued_vec[i]   = (state_q[i] == ENT_ISSUED);
        end
    end

    // Lowest free entry takes the issue
    // Credits guarantee a free entry exists whenever issue_valid_i is high
    always_comb begin
        alloc_we_o = '0;
        if (issue_valid_i && !flush_i) begin
            // Scan downward so the lowest hit wins
            for (int i = RS_DEPTH - 1; i >= 0; i--) begin
                if (free_vec[i]) begin
                    alloc_we_o    = '0;
                    alloc_we_o[i] = 1'b1;
                end
            end
        end
    end

    // Lowest-index ready entry dispatches
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (eligible_vec[i]) begin
                pick_valid = 1'b1;
                pick_idx   = rs_idx_t'(i);
            end
        end
    end

    // Entry state machines
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= ENT_FREE;
            end
        end else if (flush_i) begin
            // Flushed entries give back no credit
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= ENT_FREE;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case (state_q[i])
                    ENT_FREE: begin
                        if (alloc_we_o[i]) begin
                            state_q[i] <= ENT_WAIT;
                        end
                    end
                    ENT_WAIT: begin
                        if (pick_valid && (pick_idx == rs_idx_t'(i))) begin
                            state_q[i] <= ENT_ISSUED;
                        end
                    end
                    // Issued entry frees on the edge its credit goes out
                    default: state_q[i] <= ENT_FREE;
                endcase
            end
        end
    end

    // Dispatch pulse and the index the entry file reads during it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dispatch_q <= 1'b0;
            sel_idx_o  <= '0;
        end else if (flush_i) begin
            dispatch_q <= 1'b0;
        end else begin
            dispatch_q <= pick_valid;
            if (pick_valid) begin
                sel_idx_o <= pick_idx;
            end
        end
    end

    assign dispatch_valid_o = dispatch_q;
    // One credit per entry in its issued cycle
    assign credit_return_o  = |issued_vec;

endmodule

`default_nettype wire

//--- logic/rs_entry_file.sv
`timescale 1ns/1ns
`default_nettype none

module rs_entry_file import rs_pkg::*; (
    input  wire logic                clk,
    input  wire logic                arst_n_i,
    input  wire logic [RS_DEPTH-1:0] alloc_we_i,
    // Issue bundle
    input  wire alu_op_e             issue_op_i,
    input  wire rob_tag_t            issue_dst_tag_i,
    input  wire logic                issue_a_ready_i,
    input  wire word_t               issue_a_value_i,
    input  wire rob_tag_t            issue_a_tag_i,
    input  wire logic                issue_b_ready_i,
    input  wire word_t               issue_b_value_i,
    input  wire rob_tag_t            issue_b_tag_i,
    // Own ALU result bus
    input  wire logic                int_cdb_valid_i,
    input  wire rob_tag_t            int_cdb_tag_i,
    input  wire word_t               int_cdb_value_i,
    // Results from other units
    input  wire logic                ext_cdb_valid_i,
    input  wire rob_tag_t            ext_cdb_tag_i,
    input  wire word_t               ext_cdb_value_i,
    input  wire rs_idx_t             sel_idx_i,
    output logic [RS_DEPTH-1:0]      operands_ready_o,
    output alu_op_e                  sel_op_o,
    output word_t                    sel_a_o,
    output word_t                    sel_b_o,
    output rob_tag_t                 sel_dst_tag_o
);

    // Payload storage
    alu_op_e             op_q    [RS_DEPTH];
    rob_tag_t            dst_q   [RS_DEPTH];
    word_t               a_val_q [RS_DEPTH];
    word_t               b_val_q [RS_DEPTH];
    rob_tag_t            a_tag_q [RS_DEPTH];
    rob_tag_t            b_tag_q [RS_DEPTH];

    // Operand ready bits
    logic [RS_DEPTH-1:0] a_rdy_q;
    logic [RS_DEPTH-1:0] b_rdy_q;

    // Next ready bit on top of the next value
    logic [XLEN:0]       a_next  [RS_DEPTH];
    logic [XLEN:0]       b_next  [RS_DEPTH];

    // Look for a tag on both buses
    // A live tag shows up on at most one of them
    function automatic logic [XLEN:0] snoop(input rob_tag_t tag);
        logic [XLEN:0] res;
        res = '0;
        if (ext_cdb_valid_i && (ext_cdb_tag_i == tag)) begin
            res = {1'b1, ext_cdb_value_i};
        end
        if (int_cdb_valid_i && (int_cdb_tag_i == tag)) begin
            res = {1'b1, int_cdb_value_i};
        end
        return res;
    endfunction

    // Shared update rule for operands a and b
    function automatic logic [XLEN:0] operand_next(
        input logic     load,
        input logic     iss_rdy,
        input word_t    iss_val,
        input rob_tag_t iss_tag,
        input logic     cur_rdy,
        input word_t    cur_val,
        input rob_tag_t cur_tag
    );
        logic [XLEN:0] hit;
        logic [XLEN:0] res;
        // On issue the incoming tag is checked, else the stored one
        hit = snoop(load ? iss_tag : cur_tag);
        if (load) begin
            // Same-cycle broadcast wakes the operand at issue
            res = iss_rdy ? {1'b1, iss_val} : hit;
        end else if (!cur_rdy && hit[XLEN]) begin
            res = hit;
        end else begin
            res = {cur_rdy, cur_val};
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            a_next[i] = operand_next(alloc_we_i[i], issue_a_ready_i, issue_a_value_i,
                                     issue_a_tag_i, a_rdy_q[i], a_val_q[i], a_tag_q[i]);
            b_next[i] = operand_next(alloc_we_i[i], issue_b_ready_i, issue_b_value_i,
                                     issue_b_tag_i, b_rdy_q[i], b_val_q[i], b_tag_q[i]);
        end
    end

    // Ready bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_rdy_q <= '0;
            b_rdy_q <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                a_rdy_q[i] <= a_next[i][XLEN];
                b_rdy_q[i] <= b_next[i][XLEN];
            end
        end
    end

    // Values, tags and operation
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            a_val_q[i] <= a_next[i][XLEN-1:0];
            b_val_q[i] <= b_next[i][XLEN-1:0];
            if (alloc_we_i[i]) begin
                op_q[i]    <= issue_op_i;
                dst_q[i]   <= issue_dst_tag_i;
                a_tag_q[i] <= issue_a_tag_i;
                b_tag_q[i] <= issue_b_tag_i;
            end
        end
    end

    // Both operands in hand, qualified by state in the controller
    assign operands_ready_o = a_rdy_q & b_rdy_q;

    // Read port for the dispatching entry
    assign sel_op_o      = op_q[sel_idx_i];
    assign sel_a_o       = a_val_q[sel_idx_i];
    assign sel_b_o       = b_val_q[sel_idx_i];
    assign sel_dst_tag_o = dst_q[sel_idx_i];

endmodule

`default_nettype wire

//--- logic/rs_pkg.sv
`default_nettype none

package rs_pkg;

    // Reservation station sizing
    localparam int RS_DEPTH = 4;
    localparam int IDX_W    = $clog2(RS_DEPTH);

    // 32-entry reorder buffer
    localparam int TAG_W = 5;

    // Integer datapath width
    localparam int XLEN = 32;

    // Operand and result values
    typedef logic [XLEN-1:0]  word_t;
    // Producer and destination tags
    typedef logic [TAG_W-1:0] rob_tag_t;
    // Station entry index
    typedef logic [IDX_W-1:0] rs_idx_t;

    // Shifts use the low five bits of b, compares give 1 or 0
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Issued lasts one cycle, then the entry is free again
    typedef enum logic [1:0] {
        ENT_FREE   = 2'd0,
        ENT_WAIT   = 2'd1,
        ENT_ISSUED = 2'd2
    } entry_state_e;

endpackage

`default_nettype wire

//--- ooo_alu_cluster.f
logic/rs_pkg.sv
logic/rs_ctrl.sv
logic/rs_entry_file.sv
logic/alu_pipe.sv
logic/ooo_alu_cluster.sv
verif/ooo_alu_cluster_props.sv
verif/ooo_alu_cluster_tb.sv

//--- verif/ooo_alu_cluster_props.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_alu_cluster_props import rs_pkg::*; (
    input wire logic                clk,
    input wire logic                arst_n_i,
    input wire logic                flush_i,
    input wire logic                issue_valid_i,
    input wire logic [RS_DEPTH-1:0] alloc_we_o,
    input wire logic                dispatch_valid_o,
    input wire logic                credit_return_o
);

    // One credit goes back with every dispatch
    credit_matches_dispatch: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        credit_return_o == dispatch_valid_o
    ) else $error("credit_return_o differs from dispatch_valid_o");

    // Every accepted issue lands in exactly one entry, nothing else writes
    alloc_onehot: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (issue_valid_i && !flush_i) ? $onehot(alloc_we_o) : (alloc_we_o == '0)
    ) else $error("alloc_we_o is not one-hot for an accepted issue");

    // Flush kills the dispatch of the next cycle
    no_dispatch_after_flush: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !dispatch_valid_o
    ) else $error("dispatch in the cycle after a flush");

endmodule

bind rs_ctrl ooo_alu_cluster_props u_ooo_alu_cluster_props (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i),
    .alloc_we_o       (alloc_we_o),
    .dispatch_valid_o (dispatch_valid_o),
    .credit_return_o  (credit_return_o)
);

`default_nettype wire

//--- verif/ooo_alu_cluster_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_alu_cluster_tb import rs_pkg::*; ();

    // Total instruction count sizes the timeout
    localparam int N_INSTR = 229;
    localparam int LIMIT   = 20 * N_INSTR + 200;
    localparam int N_TAGS  = 1 << TAG_W;

    logic     clk;
    logic     arst_n_i;
    logic     flush_i;
    logic     issue_valid_i;
    alu_op_e  issue_op_i;
    rob_tag_t issue_dst_tag_i;
    logic     issue_a_ready_i;
    word_t    issue_a_value_i;
    rob_tag_t issue_a_tag_i;
    logic     issue_b_ready_i;
    word_t    issue_b_value_i;
    rob_tag_t issue_b_tag_i;
    logic     ext_cdb_valid_i;
    rob_tag_t ext_cdb_tag_i;
    word_t    ext_cdb_value_i;
    logic     credit_return_o;
    logic     cdb_valid_o;
    rob_tag_t cdb_tag_o;
    word_t    cdb_value_o;

    // Issuer and scoreboard state
    int       credits = RS_DEPTH;
    int       credit_seen;
    int       outstanding;
    int       issued;
    int       completed;
    int       errors;
    int       tests_run;
    int       cyc;
    int       timeout_cnt;
    logic     exp_valid [N_TAGS];
    word_t    exp_val   [N_TAGS];
    logic     ext_pend  [N_TAGS];
    word_t    ext_val   [N_TAGS];
    int       refcnt    [N_TAGS];
    logic     dep_a     [N_TAGS];
    logic     dep_b     [N_TAGS];
    rob_tag_t src_a     [N_TAGS];
    rob_tag_t src_b     [N_TAGS];
    int       issue_cyc [N_TAGS];
    int       lat       [N_TAGS];

    ooo_alu_cluster u_ooo_alu_cluster (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Expected result from the operation rules
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA: begin
                r = a >> sh;
                // Fill vacated bits with the sign
                if (a[31]) r = r | ~(32'hffff_ffff >> sh);
            end
            ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: r = {31'b0, a < b};
            default:  r = '0;
        endcase
        return r;
    endfunction

    // Sample outputs mid-cycle where they are stable
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (credit_return_o) begin
                credits++;
                credit_seen++;
                if (credits > RS_DEPTH) begin
                    errors++;
                    $display("credit count rose above the station depth at %0t", $time);
                end
            end
            if (cdb_valid_o) begin
                if (!exp_valid[cdb_tag_o]) begin
                    errors++;
                    $display("result for tag %0d was not expected at %0t", cdb_tag_o, $time);
                end else begin
                    check("cdb_value_o", cdb_value_o, exp_val[cdb_tag_o]);
                    exp_valid[cdb_tag_o] = 1'b0;
                    lat[cdb_tag_o] = cyc - issue_cyc[cdb_tag_o];
                    outstanding--;
                    completed++;
                    if (dep_a[cdb_tag_o]) refcnt[src_a[cdb_tag_o]]--;
                    if (dep_b[cdb_tag_o]) refcnt[src_b[cdb_tag_o]]--;
                end
            end
            // Issue takes effect at the coming edge
            if (issue_valid_i && !flush_i) issue_cyc[issue_dst_tag_i] = cyc + 1;
            cyc++;
        end
    end

    // Next rising edge with all pulses cleared
    task automatic tick();
        @(posedge clk);
        issue_valid_i   <= 1'b0;
        ext_cdb_valid_i <= 1'b0;
        flush_i         <= 1'b0;
    endtask

    task automatic hold_for_credit();
        while (credits == 0) tick();
    endtask

    // Operands still waiting on a live producer are sent as tags
    task automatic issue_instr(input alu_op_e op, input rob_tag_t dst,
                               input logic a_dep, input rob_tag_t a_src, input word_t a_val,
                               input logic b_dep, input rob_tag_t b_src, input word_t b_val);
        logic sa;
        logic sb;
        sa = a_dep && (exp_valid[a_src] || ext_pend[a_src]);
        sb = b_dep && (exp_valid[b_src] || ext_pend[b_src]);
        issue_valid_i   <= 1'b1;
        issue_op_i      <= op;
        issue_dst_tag_i <= dst;
        issue_a_ready_i <= !sa;
        issue_a_value_i <= sa ? '0 : a_val;
        issue_a_tag_i   <= a_src;
        issue_b_ready_i <= !sb;
        issue_b_value_i <= sb ? '0 : b_val;
        issue_b_tag_i   <= b_src;
        dep_a[dst] = sa;
        dep_b[dst] = sb;
        src_a[dst] = a_src;
        src_b[dst] = b_src;
        if (sa) refcnt[a_src]++;
        if (sb) refcnt[b_src]++;
        exp_valid[dst] = 1'b1;
        exp_val[dst]   = alu_ref(op, a_val, b_val);
        credits--;
        outstanding++;
        issued++;
    endtask

    task automatic send_ext(input rob_tag_t tag);
        ext_cdb_valid_i <= 1'b1;
        ext_cdb_tag_i   <= tag;
        ext_cdb_value_i <= ext_val[tag];
        ext_pend[tag] = 1'b0;
    endtask

    task automatic drain();
        do tick(); while (outstanding != 0 || credits != RS_DEPTH);
    endtask

    task automatic report(input string name, input int err_start);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic ready_ops();
        alu_op_e ops [12];
        word_t   av  [12];
        word_t   bv  [12];
        int      e;
        e = errors;
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
                ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_SLT, ALU_SLTU};
        // Overflow, borrow, negative shift amounts, signed against unsigned
        av = '{32'h7fff_ffff, 32'h0, 32'hf0f0_1234, 32'h0f00_0001, 32'haaaa_5555,
               32'h8000_0001, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff,
               32'hffff_ffff, 32'h1, 32'h1};
        bv = '{32'h1, 32'h1, 32'h0ff0_ff00, 32'h00f0_0010, 32'hffff_0000,
               32'hffff_ffe1, 32'hffff_ffff, 32'hffff_ffe4, 32'h1, 32'h1,
               32'hffff_ffff, 32'hffff_ffff};
        for (int i = 0; i < 12; i++) begin
            tick();
            issue_instr(ops[i], rob_tag_t'(i), 1'b0, '0, av[i], 1'b0, '0, bv[i]);
            drain();
            check("issue to cdb latency", lat[i], 3);
        end
        report("ready_ops", e);
    endtask

    task automatic ext_wakeup();
        int e;
        e = errors;
        ext_pend[20] = 1'b1;
        ext_val[20]  = 32'h10;
        ext_pend[21] = 1'b1;
        ext_val[21]  = 32'd30;
        tick();
        issue_instr(ALU_ADD, 5'd1, 1'b1, 5'd20, ext_val[20], 1'b0, '0, 32'd5);
        tick();
        issue_instr(ALU_SUB, 5'd2, 1'b0, '0, 32'd100, 1'b1, 5'd21, ext_val[21]);
        repeat (10) tick();
        check("outstanding", outstanding, 2);
        send_ext(5'd21);
        repeat (5) tick();
        check("outstanding", outstanding, 1);
        send_ext(5'd20);
        drain();
        report("ext_wakeup", e);
    endtask

    task automatic internal_forwarding();
        int e;
        e = errors;
        tick();
        issue_instr(ALU_ADD, 5'd3, 1'b0, '0, 32'd1, 1'b0, '0, 32'd2);
        tick();
        issue_instr(ALU_ADD, 5'd4, 1'b1, 5'd3, exp_val[3], 1'b0, '0, 32'd10);
        tick();
        issue_instr(ALU_SLL, 5'd5, 1'b1, 5'd4, exp_val[4], 1'b0, '0, 32'd2);
        tick();
        hold_for_credit();
        issue_instr(ALU_XOR, 5'd6, 1'b1, 5'd5, exp_val[5], 1'b1, 5'd3, exp_val[3]);
        tick();
        hold_for_credit();
        issue_instr(ALU_SUB, 5'd7, 1'b1, 5'd6, exp_val[6], 1'b1, 5'd4, exp_val[4]);
        drain();
        report("forwarding", e);
    endtask

    task automatic credit_flow();
        int e;
        int c0;
        e = errors;
        c0 = credit_seen;
        ext_pend[24] = 1'b1;
        ext_val[24]  = 32'h100;
        for (int i = 0; i < RS_DEPTH; i++) begin
            tick();
            issue_instr(ALU_ADD, rob_tag_t'(8 + i), 1'b1, 5'd24, ext_val[24], 1'b0, '0, i);
        end
        repeat (10) tick();
        check("credits", credits, 0);
        check("credits returned", credit_seen - c0, 0);
        send_ext(5'd24);
        drain();
        check("credits returned", credit_seen - c0, RS_DEPTH);
        check("credits", credits, RS_DEPTH);
        report("credits", e);
    endtask

    task automatic flush_recovery();
        int e;
        e = errors;
        ext_pend[28] = 1'b1;
        ext_val[28]  = 32'h55;
        for (int i = 0; i < 3; i++) begin
            tick();
            issue_instr(ALU_OR, rob_tag_t'(12 + i), 1'b1, 5'd28, ext_val[28], 1'b0, '0, i);
        end
        repeat (5) tick();
        // Wake all three so the flush lands on a ready entry about to dispatch
        send_ext(5'd28);
        tick();
        flush_i <= 1'b1;
        tick();
        // Flushed work is gone and the issuer starts over with full credit
        for (int t = 12; t < 15; t++) exp_valid[t] = 1'b0;
        outstanding = 0;
        credits = RS_DEPTH;
        repeat (10) tick();
        for (int i = 0; i < 3; i++) begin
            tick();
            issue_instr(ALU_SRA, rob_tag_t'(15 + i), 1'b0, '0, 32'h8000_00f0, 1'b0, '0, i + 3);
        end
        drain();
        check("credits", credits, RS_DEPTH);
        report("flush", e);
    endtask

    function automatic word_t edge_word();
        case ($urandom % 4)
            0:       return '0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000 ^ ($urandom % 4);
            default: return $urandom;
        endcase
    endfunction

    // Ready value, live internal producer, or an external tag
    task automatic pick_operand(output logic dep, output rob_tag_t tag, output word_t val);
        int r;
        int s;
        int t;
        dep = 1'b0;
        tag = '0;
        val = edge_word();
        r = $urandom % 3;
        s = $urandom % 24;
        for (int k = 0; k < 24 && r == 1 && !dep; k++) begin
            t = (s + k) % 24;
            if (exp_valid[t]) begin
                dep = 1'b1;
                tag = t;
                val = exp_val[t];
            end
        end
        s = $urandom % 8;
        for (int k = 0; k < 8 && r == 2 && !dep; k++) begin
            t = 24 + (s + k) % 8;
            if (ext_pend[t] || refcnt[t] == 0) begin
                if (!ext_pend[t]) begin
                    ext_pend[t] = 1'b1;
                    ext_val[t]  = edge_word();
                end
                dep = 1'b1;
                tag = t;
                val = ext_val[t];
            end
        end
    endtask

    task automatic broadcast_pending();
        int s;
        int t;
        logic sent;
        sent = 1'b0;
        s = $urandom % 8;
        for (int k = 0; k < 8 && !sent; k++) begin
            t = 24 + (s + k) % 8;
            if (ext_pend[t]) begin
                send_ext(t);
                sent = 1'b1;
            end
        end
    endtask

    task automatic random_traffic();
        int       e;
        int       n;
        int       s;
        int       dst;
        logic     ad;
        logic     bd;
        rob_tag_t at;
        rob_tag_t bt;
        word_t    av;
        word_t    bv;
        e = errors;
        n = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            refcnt[t] = 0;
            dep_a[t]  = 1'b0;
            dep_b[t]  = 1'b0;
        end
        while (n < 200) begin
            tick();
            dst = -1;
            s = $urandom % 24;
            for (int k = 0; k < 24 && dst < 0; k++) begin
                if (!exp_valid[(s + k) % 24] && refcnt[(s + k) % 24] == 0) dst = (s + k) % 24;
            end
            if (credits > 0 && dst >= 0 && ($urandom % 4) != 0) begin
                pick_operand(ad, at, av);
                pick_operand(bd, bt, bv);
                issue_instr(alu_op_e'($urandom % 10), dst, ad, at, av, bd, bt, bv);
                n++;
            end
            if (($urandom % 3) == 0) broadcast_pending();
        end
        while (outstanding != 0) begin
            tick();
            broadcast_pending();
        end
        drain();
        check("credits", credits, RS_DEPTH);
        for (int t = 0; t < N_TAGS; t++) check("tag still pending", exp_valid[t], 1'b0);
        report("random", e);
    endtask

    initial begin
        while (timeout_cnt < LIMIT) begin
            @(posedge clk);
            timeout_cnt++;
        end
        $display("run stopped after %0d cycles without finishing the tests", LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'h5c3a_15d0));
        for (int t = 0; t < N_TAGS; t++) begin
            exp_valid[t] = 1'b0;
            ext_pend[t]  = 1'b0;
            refcnt[t]    = 0;
            dep_a[t]     = 1'b0;
            dep_b[t]     = 1'b0;
        end
        arst_n_i        = 1'b0;
        flush_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_op_i      = ALU_ADD;
        issue_dst_tag_i = '0;
        issue_a_ready_i = 1'b0;
        issue_a_value_i = '0;
        issue_a_tag_i   = '0;
        issue_b_ready_i = 1'b0;
        issue_b_value_i = '0;
        issue_b_tag_i   = '0;
        ext_cdb_valid_i = 1'b0;
        ext_cdb_tag_i   = '0;
        ext_cdb_value_i = '0;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        tick();
        ready_ops();
        ext_wakeup();
        internal_forwarding();
        credit_flow();
        flush_recovery();
        random_traffic();
        $display("tests %0d, issued %0d, completed %0d, errors %0d",
                 tests_run, issued, completed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
